/* Bender.yml */
package:
  name: eth_core

sources:
  - src/eth_pkg.sv
  - src/eth_regs_pkg.sv
  - src/eth_buf_if.sv
  - src/eth_cdc_sync.sv
  - src/eth_buf_ram.sv
  - src/eth_crc32.sv
  - src/eth_tx.sv
  - src/eth_rx.sv
  - src/eth_core.sv
  - target: test
    files:
      - tb/eth_core_tb.sv

/* src/eth_buf_if.sv */
`timescale 1ns/10ps

// One byte-wide port of a frame buffer
interface eth_buf_if #(
   parameter int BUF_ADDR_W = 11
);

   logic                  en;     // Access strobe
   logic                  we;     // Write when set, read otherwise
   logic [BUF_ADDR_W-1:0] addr;   // Byte address
   logic [7:0]            wdata;
   logic [7:0]            rdata;  // Valid one clock after read strobe

   // Side issuing accesses
   modport master (
      output en, we, addr, wdata,
      input  rdata
   );

   // Memory side
   modport mem (
      input  en, we, addr, wdata,
      output rdata
   );

endinterface

/* src/eth_buf_ram.sv */
`timescale 1ns/10ps

// Dual clock byte buffer between host and MII domains
module eth_buf_ram #(
   parameter int BUF_ADDR_W = 11
) (
   input  logic   wr_clk_i,
   input  logic   rd_clk_i,
   eth_buf_if.mem wr_port,  // Filling side
   eth_buf_if.mem rd_port   // Draining side
);

   logic [7:0] mem [0:(1<<BUF_ADDR_W)-1];

   always_ff @(posedge wr_clk_i) begin
      if (wr_port.en && wr_port.we) begin
         mem[wr_port.addr] <= wr_port.wdata;
      end
   end

   // Registered read that holds while en low
   always_ff @(posedge rd_clk_i) begin
      if (rd_port.en) rd_port.rdata <= mem[rd_port.addr];
   end

   // Drain side master must never write
   rd_port_no_write: assert property (@(posedge rd_clk_i) rd_port.en |-> !rd_port.we)
      else $error("Write strobe on buffer read port");

endmodule

/* src/eth_cdc_sync.sv */
`timescale 1ns/10ps

// Level synchronizer into clk_i domain
module eth_cdc_sync #(
   parameter int DATA_W = 1
) (
   input  logic              clk_i,     // Destination clock
   input  logic              arst_n_i,
   input  logic [DATA_W-1:0] signal_i,  // Source domain level
   output logic [DATA_W-1:0] signal_o
);

   logic [DATA_W-1:0] meta;  // First stage, may go metastable

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         meta     <= '0;
         signal_o <= '0;
      end else begin
         meta     <= signal_i;
         signal_o <= meta;  // Second stage settles
      end
   end

endmodule

/* src/eth_core.sv */
`timescale 1ns/10ps

// Ethernet MAC core, host register bus plus MII
module eth_core #(
   parameter int BUF_ADDR_W = 11
) (
   input  logic                                clk_i,     // Host clock
   input  logic                                arst_n_i,
   input  logic                                host_valid_i,
   input  logic                                host_we_i,
   input  logic [BUF_ADDR_W:0]                 host_addr_i,  // MSB picks buffer window
   input  logic [eth_regs_pkg::HOST_DATA_W-1:0] host_wdata_i,
   output logic [eth_regs_pkg::HOST_DATA_W-1:0] host_rdata_o,
   output logic                                host_rvalid_o,
   output logic                                irq_o,     // Frame waiting
   input  logic                                tx_clk_i,
   output logic                                tx_en_o,
   output logic [3:0]                          tx_d_o,
   input  logic                                rx_clk_i,
   input  logic                                rx_dv_i,
   input  logic [3:0]                          rx_d_i
);

   import eth_regs_pkg::*;

   logic                   send, crc_en, rcv_ack;  // CTRL bits
   logic [10:0]            tx_nbytes;
   logic                   buf_sel;
   logic                   rd_buf_q;               // Pending read targets rx buffer
   logic [HOST_DATA_W-1:0] reg_rdata, reg_rdata_q;
   logic                   eth_send, eth_crc_en, eth_rcv_ack;
   logic [10:0]            eth_tx_nbytes;
   logic                   eth_tx_ready, tx_ready;
   logic                   eth_data_rcvd, rx_rcvd;
   logic                   eth_crc_err, crc_err;
   logic [BUF_ADDR_W-1:0]  eth_rx_nbytes, rx_nbytes;

   eth_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) tx_wr ();  // Host fills tx buffer
   eth_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) tx_rd ();
   eth_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) rx_wr ();
   eth_buf_if #(.BUF_ADDR_W(BUF_ADDR_W)) rx_rd ();  // Host drains rx buffer

   assign buf_sel = host_addr_i[BUF_ADDR_W];

   // Buffer window, writes to tx and reads from rx
   assign tx_wr.en    = host_valid_i & host_we_i & buf_sel;
   assign tx_wr.we    = 1'b1;
   assign tx_wr.addr  = host_addr_i[BUF_ADDR_W-1:0];
   assign tx_wr.wdata = host_wdata_i[7:0];
   assign rx_rd.en    = host_valid_i & ~host_we_i & buf_sel;
   assign rx_rd.we    = 1'b0;
   assign rx_rd.addr  = host_addr_i[BUF_ADDR_W-1:0];
   assign rx_rd.wdata = '0;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         send          <= 1'b0;
         crc_en        <= 1'b0;
         rcv_ack       <= 1'b0;
         tx_nbytes     <= '0;
         host_rvalid_o <= 1'b0;
      end else begin
         host_rvalid_o <= host_valid_i & ~host_we_i;  // Same latency for regs and buffer
         if (host_valid_i && host_we_i && !buf_sel) begin
            case (eth_reg_e'(host_addr_i[2:0]))
               REG_CTRL: begin
                  send    <= host_wdata_i[CTRL_SEND_BIT];
                  crc_en  <= host_wdata_i[CTRL_CRC_EN_BIT];
                  rcv_ack <= host_wdata_i[CTRL_RCV_ACK_BIT];
               end
               REG_TX_NBYTES: tx_nbytes <= host_wdata_i[10:0];
               default: ;  // Status registers ignore writes
            endcase
         end
      end
   end

   always_comb begin
      reg_rdata = '0;
      case (eth_reg_e'(host_addr_i[2:0]))
         REG_CTRL: begin
            reg_rdata[CTRL_SEND_BIT]    = send;
            reg_rdata[CTRL_CRC_EN_BIT]  = crc_en;
            reg_rdata[CTRL_RCV_ACK_BIT] = rcv_ack;
         end
         REG_TX_NBYTES: reg_rdata[10:0] = tx_nbytes;
         REG_STATUS: begin
            reg_rdata[STAT_TX_READY_BIT] = tx_ready;
            reg_rdata[STAT_RX_RCVD_BIT]  = rx_rcvd;
            reg_rdata[STAT_CRC_ERR_BIT]  = crc_err;
         end
         REG_RX_NBYTES: reg_rdata[BUF_ADDR_W-1:0] = rx_nbytes;
         default: ;
      endcase
   end

   always_ff @(posedge clk_i) begin
      rd_buf_q    <= buf_sel;
      reg_rdata_q <= reg_rdata;
   end

   assign host_rdata_o = rd_buf_q ? HOST_DATA_W'(rx_rd.rdata) : reg_rdata_q;
   assign irq_o        = rx_rcvd;

   // Host to tx clock
   eth_cdc_sync #(.DATA_W(1)) send_sync (
      .clk_i(tx_clk_i), .arst_n_i(arst_n_i), .signal_i(send), .signal_o(eth_send));
   eth_cdc_sync #(.DATA_W(1)) crc_en_sync (
      .clk_i(tx_clk_i), .arst_n_i(arst_n_i), .signal_i(crc_en), .signal_o(eth_crc_en));
   eth_cdc_sync #(.DATA_W(11)) tx_nbytes_sync (  // Stable before send rises
      .clk_i(tx_clk_i), .arst_n_i(arst_n_i), .signal_i(tx_nbytes), .signal_o(eth_tx_nbytes));

   // Tx clock to host
   eth_cdc_sync #(.DATA_W(1)) tx_ready_sync (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .signal_i(eth_tx_ready), .signal_o(tx_ready));

   // Host to rx clock
   eth_cdc_sync #(.DATA_W(1)) rcv_ack_sync (
      .clk_i(rx_clk_i), .arst_n_i(arst_n_i), .signal_i(rcv_ack), .signal_o(eth_rcv_ack));

   // Rx clock to host, status group only sampled while RX_RCVD
   eth_cdc_sync #(.DATA_W(1)) rx_rcvd_sync (
      .clk_i(clk_i), .arst_n_i(arst_n_i), .signal_i(eth_data_rcvd), .signal_o(rx_rcvd));
   eth_cdc_sync #(.DATA_W(BUF_ADDR_W+1)) rx_stat_sync (
      .clk_i(clk_i), .arst_n_i(arst_n_i),
      .signal_i({eth_crc_err, eth_rx_nbytes}), .signal_o({crc_err, rx_nbytes}));

   eth_buf_ram #(.BUF_ADDR_W(BUF_ADDR_W)) tx_buffer (
      .wr_clk_i(clk_i), .rd_clk_i(tx_clk_i), .wr_port(tx_wr), .rd_port(tx_rd));

   eth_buf_ram #(.BUF_ADDR_W(BUF_ADDR_W)) rx_buffer (
      .wr_clk_i(rx_clk_i), .rd_clk_i(clk_i), .wr_port(rx_wr), .rd_port(rx_rd));

   eth_tx #(.BUF_ADDR_W(BUF_ADDR_W)) tx (
      .clk_i    (tx_clk_i),
      .arst_n_i (arst_n_i),
      .send_i   (eth_send),
      .crc_en_i (eth_crc_en),
      .nbytes_i (eth_tx_nbytes),
      .ready_o  (eth_tx_ready),
      .buf_port (tx_rd),
      .tx_en_o  (tx_en_o),
      .tx_d_o   (tx_d_o)
   );

   eth_rx #(.BUF_ADDR_W(BUF_ADDR_W)) rx (
      .clk_i       (rx_clk_i),
      .arst_n_i    (arst_n_i),
      .rx_dv_i     (rx_dv_i),
      .rx_d_i      (rx_d_i),
      .rcv_ack_i   (eth_rcv_ack),
      .data_rcvd_o (eth_data_rcvd),
      .crc_err_o   (eth_crc_err),
      .nbytes_o    (eth_rx_nbytes),
      .buf_port    (rx_wr)
   );

endmodule

/* src/eth_crc32.sv */
`timescale 1ns/10ps

// CRC-32, one nibble per clock
module eth_crc32 (
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         init_i,    // Load all ones
   input  logic                         en_i,      // Fold nibble_i
   input  logic [eth_pkg::NIBBLE_W-1:0] nibble_i,
   output logic [31:0]                  crc_o
);

   import eth_pkg::*;

   logic [31:0] crc_nxt;

   // Bit-serial shift, LSB of nibble first
   always_comb begin
      crc_nxt = crc_o;
      for (int i = 0; i < NIBBLE_W; i++) begin
         crc_nxt = (crc_nxt >> 1) ^ ((crc_nxt[0] ^ nibble_i[i]) ? CRC_POLY : 32'h0);
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         crc_o <= CRC_INIT;
      end else if (init_i) begin
         crc_o <= CRC_INIT;
      end else if (en_i) begin
         crc_o <= crc_nxt;
      end
   end

endmodule

/* src/eth_pkg.sv */
package eth_pkg;

   // MII data width
   localparam int NIBBLE_W = 4;

   // Frame start sequence
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam int         PREAMBLE_LEN  = 7;   // Preamble bytes before SFD
   localparam logic [7:0] SFD_BYTE      = 8'hD5;

   // Frame check sequence
   localparam int FCS_LEN = 4;  // CRC bytes appended to frame

   // Reflected CRC-32 as used by IEEE 802.3
   localparam logic [31:0] CRC_POLY = 32'hEDB88320;
   localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

   // Register value once data plus its own FCS has passed
   localparam logic [31:0] CRC_RESIDUE = 32'hDEBB20E3;

endpackage

/* src/eth_regs_pkg.sv */
package eth_regs_pkg;

   // Host data bus width
   localparam int HOST_DATA_W = 32;

   // Word registers, selected by low address bits
   typedef enum logic [2:0] {
      REG_CTRL      = 3'd0,  // Send, CRC enable, receive ack
      REG_TX_NBYTES = 3'd1,  // Frame length for next send
      REG_STATUS    = 3'd2,  // Read only
      REG_RX_NBYTES = 3'd3   // Read only, valid while RX_RCVD
   } eth_reg_e;

   // CTRL bits
   localparam int CTRL_SEND_BIT    = 0;
   localparam int CTRL_CRC_EN_BIT  = 1;
   localparam int CTRL_RCV_ACK_BIT = 2;

   // STATUS bits
   localparam int STAT_TX_READY_BIT = 0;
   localparam int STAT_RX_RCVD_BIT  = 1;
   localparam int STAT_CRC_ERR_BIT  = 2;

endpackage

/* src/eth_rx.sv */
`timescale 1ns/10ps

// MII receiver, runs on rx clock
module eth_rx #(
   parameter int BUF_ADDR_W = 11
) (
   input  logic                         clk_i,      // MII rx clock
   input  logic                         arst_n_i,
   input  logic                         rx_dv_i,
   input  logic [eth_pkg::NIBBLE_W-1:0] rx_d_i,
   input  logic                         rcv_ack_i,  // Synchronized host ack
   output logic                         data_rcvd_o,
   output logic                         crc_err_o,
   output logic [BUF_ADDR_W-1:0]        nbytes_o,   // Bytes incl. FCS
   eth_buf_if.master                    buf_port    // Rx buffer write side
);

   import eth_pkg::*;

   typedef enum logic [1:0] {HUNT, DATA, HOLD, WAIT_ACK_LOW} rx_state_e;

   rx_state_e             state;
   logic                  phase;     // Second nibble of byte when set
   logic [NIBBLE_W-1:0]   prev_nib;  // For SFD match
   logic [NIBBLE_W-1:0]   lo_nib;    // First half of current byte
   logic [BUF_ADDR_W-1:0] wr_addr;
   logic                  wr_en;
   logic                  sfd_seen;
   logic [31:0]           crc;

   // SFD arrives as 5 then D
   assign sfd_seen = rx_dv_i && (prev_nib == SFD_BYTE[3:0]) && (rx_d_i == SFD_BYTE[7:4]);
   assign wr_en    = (state == DATA) && rx_dv_i && phase;

   assign buf_port.en    = wr_en;
   assign buf_port.we    = wr_en;
   assign buf_port.addr  = wr_addr;
   assign buf_port.wdata = {rx_d_i, lo_nib};  // Low nibble came first

   eth_crc32 crc_chk (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .init_i   (state == HUNT),
      .en_i     ((state == DATA) && rx_dv_i),  // FCS nibbles included
      .nibble_i (rx_d_i),
      .crc_o    (crc)
   );

   always_ff @(posedge clk_i) begin
      if (!phase) lo_nib <= rx_d_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state       <= HUNT;
         phase       <= 1'b0;
         prev_nib    <= '0;
         wr_addr     <= '0;
         data_rcvd_o <= 1'b0;
         crc_err_o   <= 1'b0;
         nbytes_o    <= '0;
      end else begin
         prev_nib <= rx_d_i;
         case (state)
            HUNT: begin
               if (sfd_seen) begin
                  state   <= DATA;
                  phase   <= 1'b0;
                  wr_addr <= '0;
               end
            end
            DATA: begin
               if (!rx_dv_i) begin  // End of frame
                  state       <= HOLD;
                  data_rcvd_o <= 1'b1;
                  crc_err_o   <= (crc != CRC_RESIDUE);
                  nbytes_o    <= wr_addr;
               end else begin
                  phase <= ~phase;
                  if (phase) wr_addr <= wr_addr + 1'b1;
               end
            end
            HOLD: begin  // Frames here are dropped
               if (rcv_ack_i) begin
                  data_rcvd_o <= 1'b0;
                  state       <= WAIT_ACK_LOW;
               end
            end
            default: begin
               // Also let any dropped frame finish
               if (!rcv_ack_i && !rx_dv_i) state <= HUNT;
            end
         endcase
      end
   end

   // Oversized frame would overwrite buffer start
   no_addr_wrap: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) wr_en |=> (wr_addr != '0))
      else $error("Rx buffer address wrapped");

endmodule

/* src/eth_tx.sv */
`timescale 1ns/10ps

// MII transmitter, runs on tx clock
module eth_tx #(
   parameter int BUF_ADDR_W = 11
) (
   input  logic                         clk_i,     // MII tx clock
   input  logic                         arst_n_i,
   input  logic                         send_i,    // Synchronized send level
   input  logic                         crc_en_i,
   input  logic [10:0]                  nbytes_i,  // Payload length
   output logic                         ready_o,
   eth_buf_if.master                    buf_port,  // Tx buffer read side
   output logic                         tx_en_o,
   output logic [eth_pkg::NIBBLE_W-1:0] tx_d_o
);

   import eth_pkg::*;

   typedef enum logic [2:0] {IDLE, PREAMBLE, SFD, DATA, FCS, DONE} tx_state_e;

   tx_state_e           state;
   logic [10:0]         cnt;      // Byte index within state
   logic                phase;    // High nibble when set
   logic                send_q;
   logic                start;
   logic                last;     // Final byte of current state
   logic [NIBBLE_W-1:0] nib;      // Nibble for next MII cycle
   logic [31:0]         crc;
   logic [31:0]         fcs;
   logic [2:0]          fcs_idx;

   assign start   = send_i & ~send_q & (state == IDLE);  // Rising edge of send
   assign fcs     = ~crc;
   assign fcs_idx = {cnt[1:0], phase};  // Low byte first, low nibble first

   // Byte 0 fetched at start, byte k+1 during high nibble of byte k
   assign buf_port.en    = start | ((state == DATA) & phase);
   assign buf_port.we    = 1'b0;
   assign buf_port.addr  = (state == DATA) ? BUF_ADDR_W'(cnt + 11'd1) : '0;
   assign buf_port.wdata = '0;

   always_comb begin
      case (state)
         PREAMBLE: last = (cnt == 11'(PREAMBLE_LEN - 1));
         DATA:     last = (cnt == nbytes_i - 11'd1);
         FCS:      last = (cnt == 11'(FCS_LEN - 1));
         default:  last = 1'b1;  // SFD is one byte
      endcase
   end

   always_comb begin
      case (state)
         PREAMBLE: nib = phase ? PREAMBLE_BYTE[7:4] : PREAMBLE_BYTE[3:0];
         SFD:      nib = phase ? SFD_BYTE[7:4] : SFD_BYTE[3:0];
         DATA:     nib = phase ? buf_port.rdata[7:4] : buf_port.rdata[3:0];
         FCS:      nib = fcs[fcs_idx*4 +: 4];
         default:  nib = '0;
      endcase
   end

   eth_crc32 crc_gen (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .init_i   (state == SFD),   // Seeded just before payload
      .en_i     (state == DATA),  // Payload nibbles only
      .nibble_i (nib),
      .crc_o    (crc)
   );

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state   <= IDLE;
         cnt     <= '0;
         phase   <= 1'b0;
         send_q  <= 1'b0;
         ready_o <= 1'b1;
         tx_en_o <= 1'b0;
         tx_d_o  <= '0;
      end else begin
         send_q  <= send_i;
         tx_en_o <= state inside {PREAMBLE, SFD, DATA, FCS};  // Pins lag state by one
         tx_d_o  <= nib;
         case (state)
            IDLE: begin
               if (start) begin
                  ready_o <= 1'b0;
                  state   <= PREAMBLE;
               end else begin
                  ready_o <= 1'b1;  // One clock after tx_en_o drops
               end
            end
            DONE: state <= IDLE;
            default: begin
               phase <= ~phase;
               if (phase) begin
                  cnt <= last ? '0 : cnt + 11'd1;
                  if (last) begin
                     case (state)
                        PREAMBLE: state <= SFD;
                        SFD:      state <= DATA;
                        DATA:     state <= crc_en_i ? FCS : DONE;
                        default:  state <= DONE;
                     endcase
                  end
               end
            end
         endcase
      end
   end

   // Idle means quiet line
   idle_no_tx_en: assert property (
      @(posedge clk_i) disable iff (!arst_n_i) (state == IDLE) |-> !tx_en_o)
      else $error("tx_en_o high while transmitter idle");

endmodule

/* tb.f */
src/eth_pkg.sv
src/eth_regs_pkg.sv
src/eth_buf_if.sv
src/eth_cdc_sync.sv
src/eth_buf_ram.sv
src/eth_crc32.sv
src/eth_tx.sv
src/eth_rx.sv
src/eth_core.sv
tb/eth_core_tb.sv

/* tb/eth_core_tb.sv */
`timescale 1ns/10ps

module eth_core_tb;

   import eth_pkg::*;
   import eth_regs_pkg::*;

   localparam int BUF_ADDR_W  = 11;
   localparam int NUM_ROWS    = 5;
   localparam int CORRUPT_NIB = 17;    // High nibble of first payload byte
   localparam int POLL_LIMIT  = 2000;  // Status reads before giving up

   // Stimulus table where length 0 picks a random length
   int row_nbytes  [NUM_ROWS] = '{64, 64, 1, 20, 0};
   bit row_crc_en  [NUM_ROWS] = '{1, 1, 1, 0, 1};
   bit row_corrupt [NUM_ROWS] = '{0, 1, 0, 0, 0};
   bit row_crc_err [NUM_ROWS] = '{0, 1, 0, 1, 0};

   logic                  clk_i, arst_n_i;
   logic                  host_valid_i, host_we_i;
   logic [BUF_ADDR_W:0]   host_addr_i;
   logic [HOST_DATA_W-1:0] host_wdata_i, host_rdata_o;
   logic                  host_rvalid_o, irq_o;
   logic                  tx_clk_i, rx_clk_i;
   logic                  tx_en_o, rx_dv_i;
   logic [3:0]            tx_d_o, rx_d_i;

   logic [7:0] payload [0:255];
   logic [3:0] tx_nibs [$];   // Seen on the MII pins
   logic [3:0] exp_nibs [$];
   int         tx_frames  = 0;
   logic       tx_en_q    = 1'b0;
   int         lb_idx     = 0;     // Nibble index within looped frame
   logic       corrupt_on = 1'b0;
   int         mismatches = 0;
   int         failures   = 0;

   eth_core #(.BUF_ADDR_W(BUF_ADDR_W)) UUT (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .host_valid_i  (host_valid_i),
      .host_we_i     (host_we_i),
      .host_addr_i   (host_addr_i),
      .host_wdata_i  (host_wdata_i),
      .host_rdata_o  (host_rdata_o),
      .host_rvalid_o (host_rvalid_o),
      .irq_o         (irq_o),
      .tx_clk_i      (tx_clk_i),
      .tx_en_o       (tx_en_o),
      .tx_d_o        (tx_d_o),
      .rx_clk_i      (rx_clk_i),
      .rx_dv_i       (rx_dv_i),
      .rx_d_i        (rx_d_i)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   // MII clocks offset from host edges
   initial begin
      tx_clk_i = 1'b0;
      #3;
      forever #20 tx_clk_i = ~tx_clk_i;
   end

   initial begin
      rx_clk_i = 1'b0;
      #3;
      forever #20 rx_clk_i = ~rx_clk_i;
   end

   // Pin monitor sampling away from the launch edge
   always @(negedge tx_clk_i) begin
      if (tx_en_o) tx_nibs.push_back(tx_d_o);
      if (tx_en_q && !tx_en_o) tx_frames++;  // One count per contiguous burst
      tx_en_q = tx_en_o;
   end

   // Loopback with optional nibble flip
   always @(posedge tx_clk_i) begin
      rx_dv_i <= tx_en_o;
      if (corrupt_on && tx_en_o && lb_idx == CORRUPT_NIB) begin
         rx_d_i <= ~tx_d_o;
      end else begin
         rx_d_i <= tx_d_o;
      end
      lb_idx <= tx_en_o ? lb_idx + 1 : 0;
   end

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      mismatches++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
   endtask

   function automatic logic [BUF_ADDR_W:0] reg_addr(input eth_reg_e r);
      return {1'b0, BUF_ADDR_W'(r)};
   endfunction

   task automatic host_write(input logic [BUF_ADDR_W:0] addr, input logic [31:0] data);
      @(posedge clk_i);
      host_valid_i <= 1'b1;
      host_we_i    <= 1'b1;
      host_addr_i  <= addr;
      host_wdata_i <= data;
      @(posedge clk_i);
      host_valid_i <= 1'b0;
      host_we_i    <= 1'b0;
   endtask

   task automatic host_read(input logic [BUF_ADDR_W:0] addr, output logic [31:0] data);
      int t;
      @(posedge clk_i);
      host_valid_i <= 1'b1;
      host_we_i    <= 1'b0;
      host_addr_i  <= addr;
      @(posedge clk_i);
      host_valid_i <= 1'b0;
      t = 0;
      @(negedge clk_i);
      while (!host_rvalid_o && t < 10) begin  // Should already be there
         @(negedge clk_i);
         t++;
      end
      data = host_rdata_o;
      if (!host_rvalid_o) begin
         failures++;
         $display("Host read of address %h returned no rvalid pulse", addr);
      end else begin
         @(negedge clk_i);
         if (host_rvalid_o !== 1'b0) report_mismatch("host_rvalid_o", host_rvalid_o, 0);
      end
   endtask

   // Poll one STATUS bit
   task automatic wait_status(input int bit_idx, input logic val, input string name);
      logic [31:0] rd;
      int          polls;
      polls = 0;
      host_read(reg_addr(REG_STATUS), rd);
      while (rd[bit_idx] !== val && polls < POLL_LIMIT) begin
         host_read(reg_addr(REG_STATUS), rd);
         polls++;
      end
      if (rd[bit_idx] !== val) begin
         failures++;
         $display("Timed out waiting for %s to read %0d", name, val);
      end
   endtask

   // Reference CRC-32 over payload bytes giving the FCS
   function automatic logic [31:0] model_fcs(input int n);
      logic [31:0] c;
      c = CRC_INIT;
      for (int i = 0; i < n; i++) begin
         c = c ^ {24'h0, payload[i]};
         for (int b = 0; b < 8; b++) c = c[0] ? ((c >> 1) ^ CRC_POLY) : (c >> 1);
      end
      return ~c;
   endfunction

   function automatic logic [7:0] exp_rx_byte(input int i, input int n);
      logic [31:0] fcs;
      fcs = model_fcs(n);
      return (i < n) ? payload[i] : fcs[8*(i-n) +: 8];  // FCS low byte first
   endfunction

   task automatic transmit_row(input int n, input bit crc_en);
      logic [31:0] ctrl;
      int          t;
      int          frames_before;
      int          n_exp;
      for (int i = 0; i < n; i++) host_write({1'b1, BUF_ADDR_W'(i)}, {24'h0, payload[i]});
      host_write(reg_addr(REG_TX_NBYTES), n);
      exp_nibs.delete();
      n_exp = n + (crc_en ? FCS_LEN : 0);
      for (int i = 0; i < PREAMBLE_LEN; i++) begin
         exp_nibs.push_back(PREAMBLE_BYTE[3:0]);
         exp_nibs.push_back(PREAMBLE_BYTE[7:4]);
      end
      exp_nibs.push_back(SFD_BYTE[3:0]);
      exp_nibs.push_back(SFD_BYTE[7:4]);
      for (int i = 0; i < n_exp; i++) begin
         exp_nibs.push_back(exp_rx_byte(i, n) & 8'h0F);
         exp_nibs.push_back(exp_rx_byte(i, n) >> 4);
      end
      tx_nibs.delete();
      frames_before = tx_frames;
      ctrl = '0;
      ctrl[CTRL_SEND_BIT]   = 1'b1;
      ctrl[CTRL_CRC_EN_BIT] = crc_en;
      host_write(reg_addr(REG_CTRL), ctrl);
      t = 0;
      while (!tx_en_o && t < POLL_LIMIT) begin
         @(negedge clk_i);
         t++;
      end
      if (!tx_en_o) begin
         failures++;
         $display("Timed out waiting for tx_en_o after SEND");
      end
      wait_status(STAT_TX_READY_BIT, 1'b1, "TX_READY");
      host_write(reg_addr(REG_CTRL), 32'h0);  // Drop SEND for the next edge
      if (tx_frames - frames_before != 1) begin
         failures++;
         $display("tx_en_o showed %0d bursts instead of one", tx_frames - frames_before);
      end
      if (tx_nibs.size() != 2 * (PREAMBLE_LEN + 1 + n_exp)) begin
         report_mismatch("tx_en_o nibble count", tx_nibs.size(), 2 * (PREAMBLE_LEN + 1 + n_exp));
      end
      for (int i = 0; i < tx_nibs.size() && i < exp_nibs.size(); i++) begin
         if (tx_nibs[i] !== exp_nibs[i]) begin
            report_mismatch($sformatf("tx_d_o nibble %0d", i), tx_nibs[i], exp_nibs[i]);
         end
      end
   endtask

   task automatic receive_row(input int n, input bit crc_en, input bit corrupt, input bit err);
      logic [31:0] rd;
      logic [31:0] ctrl;
      logic [7:0]  exp_byte;
      int          n_exp;
      n_exp = n + (crc_en ? FCS_LEN : 0);
      wait_status(STAT_RX_RCVD_BIT, 1'b1, "RX_RCVD");
      if (irq_o !== 1'b1) report_mismatch("irq_o", irq_o, 1);
      host_read(reg_addr(REG_STATUS), rd);
      if (rd[STAT_CRC_ERR_BIT] !== err) report_mismatch("CRC_ERR", rd[STAT_CRC_ERR_BIT], err);
      host_read(reg_addr(REG_RX_NBYTES), rd);
      if (rd !== n_exp) report_mismatch("RX_NBYTES", rd, n_exp);
      for (int i = 0; i < n_exp; i++) begin
         exp_byte = exp_rx_byte(i, n);
         if (corrupt && i == (CORRUPT_NIB - 2 * (PREAMBLE_LEN + 1)) / 2) begin
            exp_byte = exp_byte ^ (CORRUPT_NIB % 2 ? 8'hF0 : 8'h0F);  // Flipped on the wire
         end
         host_read({1'b1, BUF_ADDR_W'(i)}, rd);
         if (rd !== {24'h0, exp_byte}) begin
            report_mismatch($sformatf("rx buffer byte %0d", i), rd, exp_byte);
         end
      end
      ctrl = '0;
      ctrl[CTRL_RCV_ACK_BIT] = 1'b1;
      host_write(reg_addr(REG_CTRL), ctrl);
      wait_status(STAT_RX_RCVD_BIT, 1'b0, "RX_RCVD clear");
      if (irq_o !== 1'b0) report_mismatch("irq_o", irq_o, 0);
      host_write(reg_addr(REG_CTRL), 32'h0);  // Release ack so receiver rearms
   endtask

   initial begin
      logic [31:0] rd;
      int          n;
      arst_n_i     = 1'b0;
      host_valid_i = 1'b0;
      host_we_i    = 1'b0;
      host_addr_i  = '0;
      host_wdata_i = '0;
      rx_dv_i      = 1'b0;
      rx_d_i       = '0;
      void'($urandom(18));
      repeat (3) @(posedge clk_i);
      arst_n_i <= 1'b1;
      repeat (4) @(posedge clk_i);  // Let tx_ready cross over

      // State after reset
      host_read(reg_addr(REG_STATUS), rd);
      if (rd !== 32'h1) report_mismatch("STATUS", rd, 32'h1);
      host_read(reg_addr(REG_CTRL), rd);
      if (rd !== 32'h0) report_mismatch("CTRL", rd, 32'h0);
      if (irq_o !== 1'b0) report_mismatch("irq_o", irq_o, 0);
      if (tx_en_o !== 1'b0) report_mismatch("tx_en_o", tx_en_o, 0);

      for (int r = 0; r < NUM_ROWS; r++) begin
         n = (row_nbytes[r] == 0) ? 1 + ($urandom % 200) : row_nbytes[r];
         for (int i = 0; i < n; i++) payload[i] = $urandom;
         corrupt_on = row_corrupt[r];
         $display("Row %0d: %0d bytes, crc_en %0d, corrupt %0d",
                  r, n, row_crc_en[r], row_corrupt[r]);
         transmit_row(n, row_crc_en[r]);
         receive_row(n, row_crc_en[r], row_corrupt[r], row_crc_err[r]);
      end

      $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
      if (mismatches == 0 && failures == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
